// File: cnn_consts.svh
`ifndef CNN_CONSTS_SVH
`define CNN_CONSTS_SVH

// float16 element
`define DATA_WIDTH 16

// one buffer half, offsets within it
`define FM_ADDR_WIDTH 9
`define FM_RAM_HALF 512

// map side up to 15
`define FM_SIZE_WIDTH 4

// up to 7 slices
`define DEPTH_WIDTH 3

// window side 1 to 3
`define POOL_SIZE_WIDTH 2

`define LAYER_NUM_WIDTH 4

`endif

// File: cnn_data_pkg.sv
`default_nettype none

`include "cnn_consts.svh"

package cnn_data_pkg;

	// one float16 element
	typedef logic [`DATA_WIDTH-1:0] fp16_t;

	// offset inside one half of the feature map buffer
	typedef logic [`FM_ADDR_WIDTH-1:0] fm_addr_t;

	typedef logic [`FM_SIZE_WIDTH-1:0] fm_size_t;   // map side length
	typedef logic [`DEPTH_WIDTH-1:0] depth_t;       // slice count or index

	// pooling window side
	typedef logic [`POOL_SIZE_WIDTH-1:0] pool_size_t;

endpackage

`default_nettype wire

// File: cnn_ctrl_pkg.sv
`default_nettype none

`include "cnn_consts.svh"

package cnn_ctrl_pkg;

	// encoding as on the host side, conv and fc codes unused here
	typedef enum logic [1:0] {
		LAYER_PREP = 2'd0,
		LAYER_POOL = 2'd2
	} layer_type_e;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOAD,
		ST_ISSUE,   // start one window
		ST_WAIT,    // window in flight
		ST_DONE     // result write or load finish
	} layer_state_e;

	typedef logic [`LAYER_NUM_WIDTH-1:0] layer_num_t;

endpackage

`default_nettype wire

// File: fm_buffer.sv
`default_nettype none

`include "cnn_consts.svh"

module fm_buffer (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          wr_en_i,
	input  wire                          wr_half_i,
	input  wire cnn_data_pkg::fm_addr_t  wr_addr_i,
	input  wire cnn_data_pkg::fp16_t     wr_data_i,
	input  wire                          rd_en_i,
	input  wire                          rd_first_i,
	input  wire                          rd_last_i,
	input  wire                          rd_half_i,
	input  wire cnn_data_pkg::fm_addr_t  rd_addr_i,
	input  wire cnn_data_pkg::fm_addr_t  host_rd_addr_i,
	output cnn_data_pkg::fp16_t          rd_data_o,
	output logic                         rd_valid_o,
	output logic                         rd_first_o,
	output logic                         rd_last_o,
	output cnn_data_pkg::fp16_t          host_rd_data_o
);
	import cnn_data_pkg::*;

	// half bit on top of the offset
	fp16_t mem [0:2*`FM_RAM_HALF-1];

	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			mem[{wr_half_i, wr_addr_i}] <= wr_data_i;
		end
		if (rd_en_i) begin
			rd_data_o <= mem[{rd_half_i, rd_addr_i}];
		end
		host_rd_data_o <= mem[{rd_half_i, host_rd_addr_i}];   // host sees the current half
	end

	// window markers follow the data through the read latency
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rd_valid_o <= 1'b0;
			rd_first_o <= 1'b0;
			rd_last_o  <= 1'b0;
		end else begin
			rd_valid_o <= rd_en_i;
			rd_first_o <= rd_en_i && rd_first_i;
			rd_last_o  <= rd_en_i && rd_last_i;
		end
	end

endmodule

`default_nettype wire

// File: pool_addr_gen.sv
`default_nettype none

`include "cnn_consts.svh"

module pool_addr_gen (
	input  wire                            clk,
	input  wire                            rst,
	input  wire                            win_start_i,
	input  wire                            layer_start_i,
	input  wire cnn_data_pkg::fm_size_t    fm_size_i,
	input  wire cnn_data_pkg::depth_t      fm_depth_i,
	input  wire cnn_data_pkg::pool_size_t  pool_win_size_i,
	output logic                           rd_en_o,
	output logic                           rd_first_o,
	output logic                           rd_last_o,
	output cnn_data_pkg::fm_addr_t         rd_addr_o,
	output cnn_data_pkg::fm_addr_t         out_addr_o,
	output logic                           last_win_o
);
	import cnn_data_pkg::*;

	logic busy_q;
	logic first_q;      // origin still on the first window of the layer
	fm_size_t org_row_q;
	fm_size_t org_col_q;
	depth_t slice_q;
	pool_size_t in_row_q;
	pool_size_t in_col_q;
	fm_addr_t out_addr_q;

	logic [`FM_SIZE_WIDTH:0] col_end;
	logic [`FM_SIZE_WIDTH:0] row_end;
	logic col_fits;
	logic row_fits;
	logic slice_last;
	logic row_last;
	logic col_last;
	fm_addr_t slice_base;
	fm_addr_t row_idx;
	fm_addr_t col_idx;

	// far edge of the next window along each axis
	assign col_end = {1'b0, org_col_q} + (`FM_SIZE_WIDTH+1)'(2 * pool_win_size_i);
	assign row_end = {1'b0, org_row_q} + (`FM_SIZE_WIDTH+1)'(2 * pool_win_size_i);
	assign col_fits = col_end <= {1'b0, fm_size_i};
	assign row_fits = row_end <= {1'b0, fm_size_i};
	assign slice_last = slice_q == fm_depth_i - 1'b1;
	assign last_win_o = !col_fits && !row_fits && slice_last;

	assign row_last = in_row_q == pool_win_size_i - 1'b1;
	assign col_last = in_col_q == pool_win_size_i - 1'b1;

	// slice-major, then row-major
	assign slice_base = fm_addr_t'(slice_q) * fm_addr_t'(fm_size_i) * fm_addr_t'(fm_size_i);
	assign row_idx = fm_addr_t'(org_row_q) + fm_addr_t'(in_row_q);
	assign col_idx = fm_addr_t'(org_col_q) + fm_addr_t'(in_col_q);
	assign rd_addr_o = slice_base + row_idx * fm_addr_t'(fm_size_i) + col_idx;

	assign rd_en_o = busy_q;
	assign rd_first_o = busy_q && in_row_q == '0 && in_col_q == '0;
	assign rd_last_o = busy_q && row_last && col_last;
	assign out_addr_o = out_addr_q;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			busy_q     <= 1'b0;
			first_q    <= 1'b1;
			org_row_q  <= '0;
			org_col_q  <= '0;
			slice_q    <= '0;
			in_row_q   <= '0;
			in_col_q   <= '0;
			out_addr_q <= '0;
		end else if (layer_start_i) begin
			busy_q     <= 1'b0;
			first_q    <= 1'b1;
			org_row_q  <= '0;
			org_col_q  <= '0;
			slice_q    <= '0;
			out_addr_q <= '0;
		end else if (win_start_i) begin
			busy_q   <= 1'b1;
			first_q  <= 1'b0;
			in_row_q <= '0;
			in_col_q <= '0;
			if (!first_q) begin // step past the window just finished
				out_addr_q <= out_addr_q + 1'b1;
				if (col_fits) begin
					org_col_q <= org_col_q + fm_size_t'(pool_win_size_i);
				end else begin
					org_col_q <= '0;   // partial column window dropped
					if (row_fits) begin
						org_row_q <= org_row_q + fm_size_t'(pool_win_size_i);
					end else begin
						org_row_q <= '0;
						slice_q   <= slice_q + 1'b1;
					end
				end
			end
		end else if (busy_q) begin
			if (col_last) begin
				in_col_q <= '0;
				in_row_q <= in_row_q + 1'b1;
				if (row_last) begin
					busy_q   <= 1'b0;
					in_row_q <= '0;
				end
			end else begin
				in_col_q <= in_col_q + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: max_pool_unit.sv
`default_nettype none

`include "cnn_consts.svh"

module max_pool_unit (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        in_valid_i,
	input  wire                        in_first_i,
	input  wire                        in_last_i,
	input  wire cnn_data_pkg::fp16_t   in_data_i,
	output logic                       result_valid_o,
	output cnn_data_pkg::fp16_t        result_data_o
);
	import cnn_data_pkg::*;

	fp16_t max_q;
	fp16_t max_nxt;

	// unsigned key that sorts like the float value, -0 just below +0
	function automatic fp16_t order_key(input fp16_t v);
		if (v[`DATA_WIDTH-1]) begin
			return ~v;
		end else begin
			return {1'b1, v[`DATA_WIDTH-2:0]};
		end
	endfunction

	always_comb begin
		if (in_first_i) begin
			max_nxt = in_data_i;   // new window
		end else if (order_key(in_data_i) > order_key(max_q)) begin
			max_nxt = in_data_i;
		end else begin
			max_nxt = max_q;   // ties keep the earlier one
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid_i) begin
			max_q <= max_nxt;
			if (in_last_i) begin
				result_data_o <= max_nxt;
			end
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			result_valid_o <= 1'b0;
		end else begin
			result_valid_o <= in_valid_i && in_last_i;
		end
	end

endmodule

`default_nettype wire

// File: layer_ctrl.sv
`default_nettype none

`include "cnn_consts.svh"

module layer_ctrl (
	input  wire                              clk,
	input  wire                              rst,
	input  wire cnn_ctrl_pkg::layer_type_e   layer_type_i,
	input  wire cnn_ctrl_pkg::layer_num_t    layer_num_i,
	input  wire cnn_data_pkg::fp16_t         init_fm_data_i,
	input  wire cnn_data_pkg::fm_addr_t      write_fm_addr_i,
	input  wire                              init_fm_data_done_i,
	input  wire                              result_valid_i,
	input  wire cnn_data_pkg::fp16_t         result_data_i,
	input  wire cnn_data_pkg::fm_addr_t      out_addr_i,
	input  wire                              last_win_i,
	output logic                             layer_start_o,
	output logic                             win_start_o,
	output logic                             wr_en_o,
	output logic                             wr_half_o,
	output cnn_data_pkg::fm_addr_t           wr_addr_o,
	output cnn_data_pkg::fp16_t              wr_data_o,
	output logic                             cur_half_o,
	output logic                             init_fm_ram_ready_o,
	output logic                             layer_ready_o
);
	import cnn_data_pkg::*;
	import cnn_ctrl_pkg::*;

	layer_state_e state_q;
	layer_num_t cur_num_q;
	fm_addr_t res_addr_q;
	fp16_t res_data_q;

	logic new_layer;
	logic load_en;
	logic load_wr;
	logic pool_start;
	logic pool_wr;

	assign new_layer = layer_num_i != cur_num_q;

	// loading also runs straight after reset, before any layer is ready
	assign load_en = layer_type_i == LAYER_PREP &&
		(state_q == ST_LOAD || (state_q == ST_IDLE && (new_layer || !layer_ready_o)));
	assign load_wr = load_en && !init_fm_data_done_i;
	assign pool_start = state_q == ST_IDLE && new_layer &&
		layer_type_i == LAYER_POOL && init_fm_ram_ready_o;
	assign pool_wr = state_q == ST_DONE && layer_type_i == LAYER_POOL;

	assign layer_start_o = pool_start;   // rewinds the address generator
	assign win_start_o = state_q == ST_ISSUE;

	// host load goes to half 0, results to the idle half
	assign wr_en_o = load_wr || pool_wr;
	assign wr_half_o = load_wr ? 1'b0 : ~cur_half_o;
	assign wr_addr_o = load_wr ? write_fm_addr_i : res_addr_q;
	assign wr_data_o = load_wr ? init_fm_data_i : res_data_q;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state_q             <= ST_IDLE;
			cur_num_q           <= '0;
			cur_half_o          <= 1'b0;
			init_fm_ram_ready_o <= 1'b0;
			layer_ready_o       <= 1'b0;
		end else begin
			if (state_q == ST_IDLE && new_layer) begin
				cur_num_q     <= layer_num_i;
				layer_ready_o <= 1'b0;
			end
			if (load_en) begin
				if (init_fm_data_done_i) begin
					init_fm_ram_ready_o <= 1'b1;
					state_q             <= ST_DONE;
				end else begin
					init_fm_ram_ready_o <= 1'b0;
					state_q             <= ST_LOAD;
				end
			end else begin
				case (state_q)
					ST_IDLE: begin
						if (pool_start) begin
							state_q <= ST_ISSUE;
						end
					end
					ST_LOAD: state_q <= ST_IDLE;   // type left prep mid-load
					ST_ISSUE: state_q <= ST_WAIT;
					ST_WAIT: begin
						if (result_valid_i) begin
							state_q <= ST_DONE;
						end
					end
					ST_DONE: begin
						if (pool_wr) begin
							if (last_win_i) begin
								cur_half_o    <= ~cur_half_o;   // results become the input
								layer_ready_o <= 1'b1;
								state_q       <= ST_IDLE;
							end else begin
								state_q <= ST_ISSUE;
							end
						end else begin
							cur_half_o    <= 1'b0;   // fresh map lives in half 0
							layer_ready_o <= 1'b1;
							state_q       <= ST_IDLE;
						end
					end
					default: state_q <= ST_IDLE;
				endcase
			end
		end
	end

	// result held for the write cycle
	always_ff @(posedge clk) begin
		if (result_valid_i) begin
			res_addr_q <= out_addr_i;
			res_data_q <= result_data_i;
		end
	end

endmodule

`default_nettype wire

// File: cnn_pool_layer.sv
`default_nettype none

`include "cnn_consts.svh"

module cnn_pool_layer (
	input  wire                              clk,
	input  wire                              rst,
	input  wire cnn_ctrl_pkg::layer_type_e   layer_type_i,
	input  wire cnn_ctrl_pkg::layer_num_t    layer_num_i,
	input  wire cnn_data_pkg::fp16_t         init_fm_data_i,
	input  wire cnn_data_pkg::fm_addr_t      write_fm_addr_i,
	input  wire                              init_fm_data_done_i,
	input  wire cnn_data_pkg::fm_size_t      fm_size_i,
	input  wire cnn_data_pkg::depth_t        fm_depth_i,
	input  wire cnn_data_pkg::pool_size_t    pool_win_size_i,
	input  wire cnn_data_pkg::fm_addr_t      host_rd_addr_i,
	output wire cnn_data_pkg::fp16_t         host_rd_data_o,
	output wire                              init_fm_ram_ready_o,
	output wire                              layer_ready_o
);
	import cnn_data_pkg::*;

	wire layer_start;
	wire win_start;
	wire wr_en;
	wire wr_half;
	wire cur_half;
	wire fm_addr_t wr_addr;
	wire fp16_t wr_data;

	wire rd_en;
	wire rd_first;
	wire rd_last;
	wire fm_addr_t rd_addr;
	wire fm_addr_t out_addr;
	wire last_win;

	wire buf_valid;   // read data and window markers, one cycle later
	wire buf_first;
	wire buf_last;
	wire fp16_t buf_data;

	wire result_valid;
	wire fp16_t result_data;

	layer_ctrl u_layer_ctrl (
		.clk(clk), .rst(rst),
		.layer_type_i(layer_type_i), .layer_num_i(layer_num_i),
		.init_fm_data_i(init_fm_data_i), .write_fm_addr_i(write_fm_addr_i),
		.init_fm_data_done_i(init_fm_data_done_i),
		.result_valid_i(result_valid), .result_data_i(result_data),
		.out_addr_i(out_addr), .last_win_i(last_win),
		.layer_start_o(layer_start), .win_start_o(win_start),
		.wr_en_o(wr_en), .wr_half_o(wr_half), .wr_addr_o(wr_addr), .wr_data_o(wr_data),
		.cur_half_o(cur_half),
		.init_fm_ram_ready_o(init_fm_ram_ready_o), .layer_ready_o(layer_ready_o)
	);

	pool_addr_gen u_addr_gen (
		.clk(clk), .rst(rst),
		.win_start_i(win_start), .layer_start_i(layer_start),
		.fm_size_i(fm_size_i), .fm_depth_i(fm_depth_i), .pool_win_size_i(pool_win_size_i),
		.rd_en_o(rd_en), .rd_first_o(rd_first), .rd_last_o(rd_last), .rd_addr_o(rd_addr),
		.out_addr_o(out_addr), .last_win_o(last_win)
	);

	fm_buffer u_fm_buffer (
		.clk(clk), .rst(rst),
		.wr_en_i(wr_en), .wr_half_i(wr_half), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
		.rd_en_i(rd_en), .rd_first_i(rd_first), .rd_last_i(rd_last),
		.rd_half_i(cur_half), .rd_addr_i(rd_addr), .host_rd_addr_i(host_rd_addr_i),
		.rd_data_o(buf_data), .rd_valid_o(buf_valid), .rd_first_o(buf_first),
		.rd_last_o(buf_last), .host_rd_data_o(host_rd_data_o)
	);

	max_pool_unit u_max_pool (
		.clk(clk), .rst(rst),
		.in_valid_i(buf_valid), .in_first_i(buf_first), .in_last_i(buf_last),
		.in_data_i(buf_data),
		.result_valid_o(result_valid), .result_data_o(result_data)
	);

endmodule

`default_nettype wire

// File: tb_cnn_pool_layer.sv
`default_nettype none

`include "cnn_consts.svh"

module tb_cnn_pool_layer;
	import cnn_data_pkg::*;
	import cnn_ctrl_pkg::*;

	localparam int CYCLE_LIMIT = 4000;

	// 4x4 map, row-major; negatives and a -0 next to +0
	localparam fp16_t SMALL_MAP [16] = '{
		16'h3c00, 16'hc000, 16'h8000, 16'h0000,
		16'hbc00, 16'h4200, 16'hbc00, 16'hc400,
		16'hc200, 16'hc400, 16'h4500, 16'h3800,
		16'hc600, 16'hc100, 16'h7bff, 16'hfbff
	};

	logic clk;
	logic rst;
	layer_type_e layer_type;
	layer_num_t layer_num;
	fp16_t init_data;
	fm_addr_t wr_addr;
	logic data_done;
	fm_size_t fm_size;
	depth_t fm_depth;
	pool_size_t win_size;
	fm_addr_t rd_addr;
	fp16_t rd_data;
	logic init_ready;
	logic layer_ready;

	int err_cnt = 0;
	int check_cnt = 0;
	int test_cnt = 0;
	int fail_cnt = 0;
	int cycle_cnt = 0;
	logic [31:0] lfsr_q = 32'hbfef;

	fp16_t map_q[$];   // model input, slice-major
	fp16_t exp_q[$];   // model output

	cnn_pool_layer dut0 (
		.clk(clk), .rst(rst),
		.layer_type_i(layer_type), .layer_num_i(layer_num),
		.init_fm_data_i(init_data), .write_fm_addr_i(wr_addr),
		.init_fm_data_done_i(data_done),
		.fm_size_i(fm_size), .fm_depth_i(fm_depth), .pool_win_size_i(win_size),
		.host_rd_addr_i(rd_addr),
		.host_rd_data_o(rd_data), .init_fm_ram_ready_o(init_ready),
		.layer_ready_o(layer_ready)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout: the DUT did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Test failures found");
			$finish;
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#2;   // inputs change just after the edge
	endtask

	task automatic check_fp16(input string name, input fp16_t exp_v, input fp16_t act_v);
		check_cnt++;
		if (act_v !== exp_v) begin
			err_cnt++;
			$display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
		end
	endtask

	task automatic check_flag(input string name, input logic exp_v, input logic act_v);
		check_cnt++;
		if (act_v !== exp_v) begin
			err_cnt++;
			$display("MISMATCH at %0t: %s expected %b, got %b", $time, name, exp_v, act_v);
		end
	endtask

	// galois form, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end else begin
			return s >> 1;
		end
	endfunction

	task automatic rand_bits(input int n, output logic [15:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[14:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	task automatic rand_fp16(output fp16_t v);
		logic [15:0] bits;
		logic sgn;
		logic [4:0] expo;
		logic [9:0] mant;
		rand_bits(1, bits);
		sgn = bits[0];
		rand_bits(5, bits);
		expo = bits[4:0];
		if (expo == 5'd31) begin
			expo = 5'd30;   // keeps out inf and NaN
		end
		rand_bits(10, bits);
		mant = bits[9:0];
		v = {sgn, expo, mant};
	endtask

	// a sorts strictly above b; +0 above -0
	function automatic logic fp16_above(input fp16_t a, input fp16_t b);
		if (a[`DATA_WIDTH-1] != b[`DATA_WIDTH-1]) begin
			return b[`DATA_WIDTH-1];
		end else if (!a[`DATA_WIDTH-1]) begin
			return a[`DATA_WIDTH-2:0] > b[`DATA_WIDTH-2:0];
		end else begin
			return a[`DATA_WIDTH-2:0] < b[`DATA_WIDTH-2:0];
		end
	endfunction

	task automatic pool_model(input int size, input int depth, input int win);
		int out_side;
		int base;
		fp16_t best;
		fp16_t v;
		exp_q.delete();
		out_side = size / win;   // partial windows dropped
		for (int s = 0; s < depth; s++) begin
			for (int r = 0; r < out_side; r++) begin
				for (int c = 0; c < out_side; c++) begin
					base = s * size * size + r * win * size + c * win;
					best = map_q[base];
					for (int i = 0; i < win; i++) begin
						for (int j = 0; j < win; j++) begin
							v = map_q[base + i * size + j];
							if (fp16_above(v, best)) begin
								best = v;
							end
						end
					end
					exp_q.push_back(best);
				end
			end
		end
	endtask

	// streams map_q into half 0 and checks the ready timing
	task automatic load_map(input layer_num_t num);
		layer_type = LAYER_PREP;
		layer_num = num;
		data_done = 1'b0;
		for (int i = 0; i < map_q.size(); i++) begin
			init_data = map_q[i];
			wr_addr = fm_addr_t'(i);
			next_cycle();
			check_flag("init_fm_ram_ready_o", 1'b0, init_ready);
		end
		data_done = 1'b1;
		next_cycle();
		check_flag("init_fm_ram_ready_o", 1'b1, init_ready);
		check_flag("layer_ready_o", 1'b0, layer_ready);
		data_done = 1'b0;
		next_cycle();
		check_flag("layer_ready_o", 1'b1, layer_ready);
	endtask

	task automatic run_pool(input layer_num_t num, input int size, input int depth,
			input int win);
		fm_size = fm_size_t'(size);
		fm_depth = depth_t'(depth);
		win_size = pool_size_t'(win);
		layer_type = LAYER_POOL;
		layer_num = num;
		next_cycle();
		check_flag("layer_ready_o", 1'b0, layer_ready);
		while (!layer_ready) begin
			next_cycle();
		end
	endtask

	task automatic read_results(input int count);
		for (int i = 0; i < count; i++) begin
			rd_addr = fm_addr_t'(i);
			next_cycle();
			check_fp16($sformatf("host_rd_data_o[%0d]", i), exp_q[i], rd_data);
		end
	endtask

	task automatic report_test(input string name, input int errs_at_start);
		test_cnt++;
		if (err_cnt != errs_at_start) begin
			fail_cnt++;
			$display("test %0d %s: FAILED, %0d errors", test_cnt, name, err_cnt - errs_at_start);
		end else begin
			$display("test %0d %s: ok", test_cnt, name);
		end
	endtask

	task automatic load_small_map();
		int errs_at_start;
		errs_at_start = err_cnt;
		check_flag("layer_ready_o", 1'b0, layer_ready);
		check_flag("init_fm_ram_ready_o", 1'b0, init_ready);
		map_q.delete();
		for (int i = 0; i < 16; i++) begin
			map_q.push_back(SMALL_MAP[i]);
		end
		load_map(4'd1);
		report_test("load 4x4x1", errs_at_start);
	endtask

	task automatic pool_small_map();
		int errs_at_start;
		errs_at_start = err_cnt;
		pool_model(4, 1, 2);
		run_pool(4'd2, 4, 1, 2);
		read_results(4);
		report_test("pool 4x4x1 by 2", errs_at_start);
	endtask

	task automatic pool_random_map();
		int errs_at_start;
		fp16_t v;
		errs_at_start = err_cnt;
		map_q.delete();
		for (int i = 0; i < 98; i++) begin
			rand_fp16(v);
			map_q.push_back(v);
		end
		load_map(4'd3);
		pool_model(7, 2, 3);
		run_pool(4'd4, 7, 2, 3);
		read_results(8);
		report_test("pool 7x7x2 by 3", errs_at_start);
	endtask

	// second layer reads the half the first one wrote
	task automatic pool_ping_pong();
		int errs_at_start;
		errs_at_start = err_cnt;
		map_q = exp_q;
		pool_model(2, 2, 2);
		run_pool(4'd5, 2, 2, 2);
		read_results(2);
		report_test("ping-pong 2x2x2 by 2", errs_at_start);
	endtask

	task automatic hold_layer_number();
		int errs_at_start;
		errs_at_start = err_cnt;
		repeat (20) begin
			next_cycle();
			check_flag("layer_ready_o", 1'b1, layer_ready);
		end
		read_results(2);
		report_test("hold layer number", errs_at_start);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b0;
		layer_type = LAYER_PREP;
		layer_num = '0;
		init_data = '0;
		wr_addr = '0;
		data_done = 1'b0;
		fm_size = '0;
		fm_depth = '0;
		win_size = '0;
		rd_addr = '0;
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b1;
		next_cycle();

		load_small_map();
		pool_small_map();
		pool_random_map();
		pool_ping_pong();
		hold_layer_number();

		$display("%0d tests, %0d failed, %0d checks, %0d mismatches",
			test_cnt, fail_cnt, check_cnt, err_cnt);
		if (fail_cnt == 0 && err_cnt == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
cnn_data_pkg.sv
cnn_ctrl_pkg.sv
fm_buffer.sv
pool_addr_gen.sv
max_pool_unit.sv
layer_ctrl.sv
cnn_pool_layer.sv
tb_cnn_pool_layer.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the pooling layer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f tb.f --top-module tb_cnn_pool_layer -o sim_tb_cnn_pool_layer
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/sim_tb_cnn_pool_layer > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "All tests passed!" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
